// ==== Bender.yml ====
package:
  name: ahb_matrix

export_include_dirs:
  - rtl

sources:
  - rtl/ahb_matrix_pkg.sv
  - rtl/ahb_decoder.sv
  - rtl/ahb_ram_slave.sv
  - rtl/ahb_gpio_slave.sv
  - rtl/ahb_response_mux.sv
  - rtl/ahb_matrix.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_ahb_matrix.sv

// ==== rtl/ahb_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module ahb_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`AHB_ADDR_WIDTH-1:0]   haddr,
    input  logic                         hready,
    output logic [`AHB_DEVICE_COUNT-1:0] hsel,
    output logic [`AHB_DEVICE_COUNT-1:0] hsel_r
);

    // ------------------------------------------------------------
    // Address phase select
    // ------------------------------------------------------------
    always_comb begin
        hsel    = '0;
        hsel[0] = (haddr[28:22] == `RESET_RAM_ADDR_MATCH);  // 1fc00000 - 1fffffff
        hsel[1] = (haddr[28:26] == `RAM_ADDR_MATCH);        // 00000000 - 03ffffff
        hsel[2] = (haddr[28:22] == `GPIO_ADDR_MATCH);       // 1f800000 - 1fbfffff
    end

    // ------------------------------------------------------------
    // Data phase select, follows the bus only when a phase ends
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            hsel_r <= '0;
        end else if (hready) begin
            hsel_r <= hsel;
        end
    end

    // Address windows must never overlap
    a_hsel_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(hsel)
    );

endmodule

`default_nettype wire

// ==== rtl/ahb_gpio_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module ahb_gpio_slave import ahb_matrix_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  ahb_req_t                 req,
    input  logic                     hsel,
    input  logic                     hready,
    output ahb_rsp_t                 rsp,
    input  logic [`N_SWITCHES-1:0]   switches,
    input  logic [`N_BUTTONS-1:0]    buttons,
    output logic [`N_RED_LEDS-1:0]   red_leds,
    output logic [`N_GREEN_LEDS-1:0] green_leds,
    output logic [`HEX_WIDTH-1:0]    hex
);

    localparam int DW = `AHB_DATA_WIDTH;

    // Register index, haddr[4:2]
    localparam logic [2:0] REG_RED   = 3'd0;
    localparam logic [2:0] REG_GREEN = 3'd1;
    localparam logic [2:0] REG_HEX   = 3'd2;
    localparam logic [2:0] REG_SW    = 3'd3;
    localparam logic [2:0] REG_BTN   = 3'd4;

    logic       accept;
    logic [2:0] idx_q;
    logic       write_q;

    assign accept = hsel && hready &&
                    (req.htrans == HTRANS_NONSEQ || req.htrans == HTRANS_SEQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            write_q <= 1'b0;
        end else if (hready) begin
            write_q <= accept && req.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q <= req.haddr[4:2];
        end
    end

    // ------------------------------------------------------------
    // Output registers, written in the data phase
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            red_leds   <= '0;
            green_leds <= '0;
            hex        <= '0;
        end else if (write_q && hready) begin
            case (idx_q)
                REG_RED:   red_leds   <= req.hwdata[`N_RED_LEDS-1:0];
                REG_GREEN: green_leds <= req.hwdata[`N_GREEN_LEDS-1:0];
                REG_HEX:   hex        <= req.hwdata[`HEX_WIDTH-1:0];
                default:   ;                    // Read-only or unused
            endcase
        end
    end

    always_comb begin
        case (idx_q)
            REG_RED:   rsp.hrdata = DW'(red_leds);
            REG_GREEN: rsp.hrdata = DW'(green_leds);
            REG_HEX:   rsp.hrdata = DW'(hex);
            REG_SW:    rsp.hrdata = DW'(switches);
            REG_BTN:   rsp.hrdata = DW'(buttons);
            default:   rsp.hrdata = '0;
        endcase
    end

    assign rsp.hreadyout = 1'b1;
    assign rsp.hresp     = HRESP_OKAY;

endmodule

`default_nettype wire

// ==== rtl/ahb_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module ahb_matrix import ahb_matrix_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  ahb_req_t                 req,
    output ahb_rsp_t                 rsp,
    input  logic [`N_SWITCHES-1:0]   switches,
    input  logic [`N_BUTTONS-1:0]    buttons,
    output logic [`N_RED_LEDS-1:0]   red_leds,
    output logic [`N_GREEN_LEDS-1:0] green_leds,
    output logic [`HEX_WIDTH-1:0]    hex
);

    logic     [`AHB_DEVICE_COUNT-1:0] hsel;      // Address phase
    logic     [`AHB_DEVICE_COUNT-1:0] hsel_r;    // Data phase
    ahb_rsp_t [`AHB_DEVICE_COUNT-1:0] slave_rsp;
    logic                             hready;

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------
    ahb_decoder decoder (
        .clk    (clk),
        .rst    (rst),
        .haddr  (req.haddr),
        .hready (hready),
        .hsel   (hsel),
        .hsel_r (hsel_r)
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    ahb_ram_slave #(
        .ADDR_WIDTH (`RESET_RAM_ADDR_WIDTH)
    ) reset_ram (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .hsel   (hsel[0]),
        .hready (hready),
        .rsp    (slave_rsp[0])
    );

    ahb_ram_slave #(
        .ADDR_WIDTH (`RAM_ADDR_WIDTH)
    ) ram (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .hsel   (hsel[1]),
        .hready (hready),
        .rsp    (slave_rsp[1])
    );

    ahb_gpio_slave gpio (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .hsel       (hsel[2]),
        .hready     (hready),
        .rsp        (slave_rsp[2]),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .hex        (hex)
    );

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------
    ahb_response_mux response_mux (
        .hsel_r    (hsel_r),
        .slave_rsp (slave_rsp),
        .rsp       (rsp),
        .hready    (hready)
    );

endmodule

`default_nettype wire

// ==== rtl/ahb_matrix_defs.svh ====
`ifndef AHB_MATRIX_DEFS_SVH
`define AHB_MATRIX_DEFS_SVH

// ------------------------------------------------------------
// Bus
// ------------------------------------------------------------
`define AHB_ADDR_WIDTH          32
`define AHB_DATA_WIDTH          32
`define AHB_DEVICE_COUNT        3       // 0 reset RAM, 1 main RAM, 2 GPIO

// ------------------------------------------------------------
// Memories and address map
// ------------------------------------------------------------
`define RESET_RAM_ADDR_WIDTH    10      // 1 KB
`define RAM_ADDR_WIDTH          12      // 4 KB

`define RESET_RAM_ADDR_MATCH    7'h7f   // haddr[28:22], physical 1fc00000
`define RAM_ADDR_MATCH          3'h0    // haddr[28:26], physical 00000000
`define GPIO_ADDR_MATCH         7'h7e   // haddr[28:22], physical 1f800000

// ------------------------------------------------------------
// GPIO
// ------------------------------------------------------------
`define N_SWITCHES              18
`define N_BUTTONS               5
`define N_RED_LEDS              18
`define N_GREEN_LEDS            9
`define HEX_WIDTH               32

`endif

// ==== rtl/ahb_matrix_pkg.sv ====
`default_nettype none

`include "ahb_matrix_defs.svh"

package ahb_matrix_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_t;

    localparam logic HRESP_OKAY = 1'b0;

    // Master request, address phase and data phase together
    typedef struct packed {
        logic [`AHB_ADDR_WIDTH-1:0] haddr;
        htrans_t                    htrans;
        hsize_t                     hsize;
        logic                       hwrite;
        logic [`AHB_DATA_WIDTH-1:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [`AHB_DATA_WIDTH-1:0] hrdata;
        logic                       hreadyout;
        logic                       hresp;
    } ahb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/ahb_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module ahb_ram_slave import ahb_matrix_pkg::*; #(
    parameter int ADDR_WIDTH = `RAM_ADDR_WIDTH
) (
    input  logic     clk,
    input  logic     rst,
    input  ahb_req_t req,
    input  logic     hsel,
    input  logic     hready,
    output ahb_rsp_t rsp
);

    localparam int LANES = `AHB_DATA_WIDTH / 8;
    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [`AHB_DATA_WIDTH-1:0] mem [WORDS];

    logic                  accept;
    logic [LANES-1:0]      lanes;
    logic [ADDR_WIDTH-3:0] addr_q;
    logic [LANES-1:0]      lanes_q;
    logic                  write_q;

    assign accept = hsel && hready &&
                    (req.htrans == HTRANS_NONSEQ || req.htrans == HTRANS_SEQ);

    // Byte lanes, little endian
    always_comb begin
        case (req.hsize)
            HSIZE_BYTE: lanes = LANES'(1) << req.haddr[1:0];
            HSIZE_HALF: lanes = LANES'(3) << {req.haddr[1], 1'b0};
            default:    lanes = {LANES{1'b1}};
        endcase
    end

    // ------------------------------------------------------------
    // Address phase capture
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            write_q <= 1'b0;
        end else if (hready) begin
            write_q <= accept && req.hwrite;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req.haddr[ADDR_WIDTH-1:2];
            lanes_q <= lanes;
        end
    end

    // ------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (write_q && hready) begin
            for (int i = 0; i < LANES; i++) begin
                if (lanes_q[i]) begin
                    mem[addr_q][i*8 +: 8] <= req.hwdata[i*8 +: 8];
                end
            end
        end
    end

    // Read from the registered address, so a write just done is seen
    assign rsp.hrdata    = mem[addr_q];
    assign rsp.hreadyout = 1'b1;            // No wait states
    assign rsp.hresp     = HRESP_OKAY;

    a_size_word: assert property (
        @(posedge clk) disable iff (rst) accept |-> (req.hsize <= HSIZE_WORD)
    );

    a_half_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (accept && req.hsize == HSIZE_HALF) |-> !req.haddr[0]
    );

endmodule

`default_nettype wire

// ==== rtl/ahb_response_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module ahb_response_mux import ahb_matrix_pkg::*; (
    input  logic     [`AHB_DEVICE_COUNT-1:0] hsel_r,
    input  ahb_rsp_t [`AHB_DEVICE_COUNT-1:0] slave_rsp,
    output ahb_rsp_t                         rsp,
    output logic                             hready
);

    // Unmapped default is zero data, ready, OKAY.
    // Scanning downward lets the lowest selected slot win
    always_comb begin
        rsp.hrdata    = '0;
        rsp.hreadyout = 1'b1;
        rsp.hresp     = HRESP_OKAY;
        for (int i = `AHB_DEVICE_COUNT - 1; i >= 0; i--) begin
            if (hsel_r[i]) begin
                rsp = slave_rsp[i];
            end
        end
    end

    assign hready = rsp.hreadyout;

endmodule

`default_nettype wire

// ==== testbench/tb_ahb_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_defs.svh"

module tb_ahb_matrix import ahb_matrix_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 2000;   // Tests take about 130 cycles
    localparam logic [31:0] RAM_BASE       = 32'h0000_0000;
    localparam logic [31:0] RESET_RAM_BASE = 32'h1fc0_0000;
    localparam logic [31:0] GPIO_BASE      = 32'h1f80_0000;
    localparam logic [31:0] UNMAPPED_ADDR  = 32'h1000_0000;

    logic                     clk;
    logic                     rst;
    ahb_req_t                 req;
    ahb_rsp_t                 rsp;
    logic [`N_SWITCHES-1:0]   switches;
    logic [`N_BUTTONS-1:0]    buttons;
    logic [`N_RED_LEDS-1:0]   red_leds;
    logic [`N_GREEN_LEDS-1:0] green_leds;
    logic [`HEX_WIDTH-1:0]    hex;

    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          checks          = 0;
    int          cycle_count     = 0;
    int          seed;
    logic [31:0] ram_words [16];             // Expected main RAM contents

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (8)
    ) clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ahb_matrix ahb_matrix_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .hex        (hex)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Bus driver
    // ------------------------------------------------------------
    task automatic step_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic address_phase(input logic [31:0] addr, input logic write, input hsize_t size);
        req.haddr  = addr;
        req.htrans = HTRANS_NONSEQ;
        req.hwrite = write;
        req.hsize  = size;
    endtask

    task automatic check_response(input string what);
        checks++;
        if (rsp.hreadyout !== 1'b1) begin
            $display("hready was low in the %s at %0t ns", what, $time);
            protocol_errors++;
        end
        if (rsp.hresp !== HRESP_OKAY) begin
            $display("Slave answered with an error in the %s at %0t ns", what, $time);
            protocol_errors++;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, expected);
            value_errors++;
        end
    endtask

    task automatic bus_idle;
        req.htrans = HTRANS_IDLE;
        req.hwrite = 1'b0;
        step_cycle;
    endtask

    task automatic write_single(input logic [31:0] addr, input hsize_t size,
                                input logic [31:0] data);
        address_phase(addr, 1'b1, size);
        step_cycle;
        req.htrans = HTRANS_IDLE;                // Data phase
        req.hwrite = 1'b0;
        req.hwdata = data;
        @(negedge clk);
        check_response("write data phase");
        step_cycle;
    endtask

    task automatic read_single(input logic [31:0] addr, input hsize_t size,
                               output logic [31:0] data);
        address_phase(addr, 1'b0, size);
        step_cycle;
        req.htrans = HTRANS_IDLE;
        @(negedge clk);
        check_response("read data phase");
        data = rsp.hrdata;
        step_cycle;
    endtask

    // Read address phase shares the cycle with the write data phase
    task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata,
                                   output logic [31:0] rdata);
        address_phase(addr, 1'b1, HSIZE_WORD);
        step_cycle;
        req.hwdata = wdata;
        address_phase(addr, 1'b0, HSIZE_WORD);
        @(negedge clk);
        check_response("pipelined write data phase");
        step_cycle;
        req.htrans = HTRANS_IDLE;
        @(negedge clk);
        check_response("pipelined read data phase");
        rdata = rsp.hrdata;
        step_cycle;
    endtask

    // Little-endian lane merge of a write into an old word
    function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] wdata,
                                                input hsize_t size, input logic [1:0] offset);
        logic [31:0] result;
        int          first;
        int          count;
        result = old;
        case (size)
            HSIZE_BYTE: begin
                first = offset;
                count = 1;
            end
            HSIZE_HALF: begin
                first = offset & 2'b10;
                count = 2;
            end
            default: begin
                first = 0;
                count = 4;
            end
        endcase
        for (int i = first; i < first + count; i++) begin
            result[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return result;
    endfunction

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic reset_state_check;
        check_value("red_leds after reset", 32'(red_leds), 32'h0);
        check_value("green_leds after reset", 32'(green_leds), 32'h0);
        check_value("hex after reset", 32'(hex), 32'h0);
    endtask

    task automatic ram_word_rw;
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            ram_words[i] = $urandom;
            write_single(RAM_BASE + i * 32'h44, HSIZE_WORD, ram_words[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_single(RAM_BASE + i * 32'h44, HSIZE_WORD, data);
            check_value($sformatf("main RAM word %0d", i), data, ram_words[i]);
        end
    endtask

    task automatic byte_lane_merge;
        logic [31:0] base;
        logic [31:0] model;
        logic [31:0] bus;
        logic [31:0] data;
        base  = RAM_BASE + 32'h200;
        model = $urandom;
        write_single(base, HSIZE_WORD, model);
        bus = $urandom;                          // Different data on every lane
        write_single(base + 1, HSIZE_BYTE, bus);
        model = merge_write(model, bus, HSIZE_BYTE, 2'd1);
        bus = $urandom;
        write_single(base + 2, HSIZE_HALF, bus);
        model = merge_write(model, bus, HSIZE_HALF, 2'd2);
        read_single(base, HSIZE_WORD, data);
        check_value("byte 1 and upper half merge", data, model);
        bus = $urandom;
        write_single(base + 3, HSIZE_BYTE, bus);
        model = merge_write(model, bus, HSIZE_BYTE, 2'd3);
        bus = $urandom;
        write_single(base, HSIZE_HALF, bus);
        model = merge_write(model, bus, HSIZE_HALF, 2'd0);
        read_single(base, HSIZE_WORD, data);
        check_value("byte 3 and lower half merge", data, model);
    endtask

    task automatic memory_separation;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        a = $urandom;
        b = ~a;
        write_single(RESET_RAM_BASE + 32'h80, HSIZE_WORD, a);
        write_single(RAM_BASE + 32'h80, HSIZE_WORD, b);
        read_single(RESET_RAM_BASE + 32'h80, HSIZE_WORD, data);
        check_value("reset RAM word", data, a);
        read_single(RAM_BASE + 32'h80, HSIZE_WORD, data);
        check_value("main RAM word at same offset", data, b);
    endtask

    task automatic pipelined_access;
        logic [31:0] wdata;
        logic [31:0] rdata;
        for (int i = 0; i < 4; i++) begin
            wdata = $urandom;
            write_then_read(RAM_BASE + 32'h300 + i * 4, wdata, rdata);
            check_value($sformatf("pipelined read %0d", i), rdata, wdata);
        end
        wdata = $urandom;
        write_then_read(RESET_RAM_BASE + 32'h10, wdata, rdata);
        check_value("pipelined reset RAM read", rdata, wdata);
    endtask

    task automatic gpio_registers;
        logic [31:0] wdata;
        logic [31:0] data;
        wdata = $urandom;
        write_single(GPIO_BASE + 32'h0, HSIZE_WORD, wdata);
        check_value("red_leds", 32'(red_leds), 32'(wdata[`N_RED_LEDS-1:0]));
        read_single(GPIO_BASE + 32'h0, HSIZE_WORD, data);
        check_value("red LED register", data, 32'(wdata[`N_RED_LEDS-1:0]));
        wdata = $urandom;
        write_single(GPIO_BASE + 32'h4, HSIZE_WORD, wdata);
        check_value("green_leds", 32'(green_leds), 32'(wdata[`N_GREEN_LEDS-1:0]));
        read_single(GPIO_BASE + 32'h4, HSIZE_WORD, data);
        check_value("green LED register", data, 32'(wdata[`N_GREEN_LEDS-1:0]));
        wdata = $urandom;
        write_single(GPIO_BASE + 32'h8, HSIZE_WORD, wdata);
        check_value("hex", 32'(hex), wdata);
        read_single(GPIO_BASE + 32'h8, HSIZE_WORD, data);
        check_value("seven-segment register", data, wdata);
        switches = `N_SWITCHES'($urandom);
        buttons  = `N_BUTTONS'($urandom);
        read_single(GPIO_BASE + 32'hc, HSIZE_WORD, data);
        check_value("switch register", data, 32'(switches));
        read_single(GPIO_BASE + 32'h10, HSIZE_WORD, data);
        check_value("button register", data, 32'(buttons));
        read_single(GPIO_BASE + 32'h14, HSIZE_WORD, data);
        check_value("unused GPIO offset", data, 32'h0);
    endtask

    task automatic unmapped_read;
        logic [31:0] data;
        read_single(UNMAPPED_ADDR, HSIZE_WORD, data);
        check_value("unmapped read", data, 32'h0);
        read_single(RAM_BASE + 3 * 32'h44, HSIZE_WORD, data);
        check_value("RAM read after unmapped", data, ram_words[3]);
    endtask

    initial begin
        seed       = $urandom(54);
        req        = '0;
        switches   = '0;
        buttons    = '0;
        @(negedge rst);
        reset_state_check;
        bus_idle;
        ram_word_rw;
        byte_lane_merge;
        memory_separation;
        pipelined_access;
        gpio_registers;
        unmapped_read;
        bus_idle;
        $display("Checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lines up with the testbench drive point
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/ahb_matrix_pkg.sv
rtl/ahb_decoder.sv
rtl/ahb_ram_slave.sv
rtl/ahb_gpio_slave.sv
rtl/ahb_response_mux.sv
rtl/ahb_matrix.sv
testbench/tb_clock_gen.sv
testbench/tb_ahb_matrix.sv
